// File: design/alu_imm_pkg.sv
// Immediate ALU pipeline definitions

package alu_imm_pkg;

  // Register file organisation
  localparam int PRF_BANK_COUNT     = 4;
  localparam int LOG_PRF_BANK_COUNT = 2;
  localparam int PRF_PORT_COUNT     = 2;
  localparam int LOG_PR_COUNT       = 7;

  // Reorder buffer
  localparam int LOG_ROB_ENTRIES = 6;

  // Datapath widths
  localparam int XLEN      = 32;
  localparam int IMM_WIDTH = 12;

  // Index types
  typedef logic [LOG_PRF_BANK_COUNT-1:0] bank_t;
  typedef logic [LOG_PR_COUNT-1:0]       pr_t;
  typedef logic [LOG_ROB_ENTRIES-1:0]    rob_t;

  // Immediate operations
  // Low three bits follow the RISC-V funct3 of the OP-IMM group,
  // bit 3 selects the arithmetic right shift
  typedef enum logic [3:0] {
    ALU_IMM_ADDI  = 4'b0000,
    ALU_IMM_SLLI  = 4'b0001,
    ALU_IMM_SLTI  = 4'b0010,
    ALU_IMM_SLTIU = 4'b0011,
    ALU_IMM_XORI  = 4'b0100,
    ALU_IMM_SRLI  = 4'b0101,
    ALU_IMM_ORI   = 4'b0110,
    ALU_IMM_ANDI  = 4'b0111,
    ALU_IMM_SRAI  = 4'b1101
  } alu_imm_op_t;

  // Operands and tags for the execute stage
  typedef struct packed {
    alu_imm_op_t          op;
    logic [IMM_WIDTH-1:0] imm12;
    logic [XLEN-1:0]      a;
    pr_t                  dest_pr;
    rob_t                 rob_index;
  } ex_payload_t;

  // Result as seen on the writeback port
  typedef struct packed {
    logic [XLEN-1:0] data;
    pr_t             dest_pr;
    rob_t            rob_index;
  } wb_payload_t;

endpackage

// File: design/alu_imm_stage_reg.sv
// Valid/ready stage register
`timescale 1ns/1ps

module alu_imm_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     CLK,
  input  logic     nRST,

  input  logic     in_valid,
  input  payload_t in_payload,
  output logic     in_ready,

  output logic     out_valid,
  output payload_t out_payload,
  input  logic     out_ready
);

  logic     full;
  payload_t data_q;

  // Take a new item when empty or when the current one leaves this cycle
  assign in_ready = !full || out_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      data_q <= in_payload;
    end
  end

  assign out_valid   = full;
  assign out_payload = data_q;

  // Downstream sees a frozen item for as long as it stalls
  property p_out_hold;
    @(posedge CLK) disable iff (!nRST)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_payload));
  endproperty

  a_out_hold: assert property (p_out_hold)
    else $error("stage register output changed while stalled");

  // Nothing is offered in the cycle after reset
  property p_empty_after_reset;
    @(posedge CLK) !nRST |=> !out_valid;
  endproperty

  a_empty_after_reset: assert property (p_empty_after_reset)
    else $error("stage register valid after reset");

endmodule

// File: design/alu_imm_operand_read.sv
// Issue capture and operand A select
`timescale 1ns/1ps

module alu_imm_operand_read (
  input  logic                                                 CLK,
  input  logic                                                 nRST,

  // Issue queue
  input  logic                                                 issue_valid,
  output logic                                                 issue_ready,
  input  alu_imm_pkg::alu_imm_op_t                             issue_op,
  input  logic [alu_imm_pkg::IMM_WIDTH-1:0]                    issue_imm12,
  input  logic                                                 issue_A_forward,
  input  logic                                                 issue_A_is_zero,
  input  alu_imm_pkg::bank_t                                   issue_A_bank,
  input  alu_imm_pkg::pr_t                                     issue_dest_PR,
  input  alu_imm_pkg::rob_t                                    issue_ROB_index,

  // Read arbiter grant, same cycle as the issue
  input  logic                                                 A_reg_read_ack,
  input  logic                                                 A_reg_read_port,

  // Register read and forwarding buses, cycle after the issue
  input  logic [alu_imm_pkg::PRF_BANK_COUNT-1:0][alu_imm_pkg::PRF_PORT_COUNT-1:0]
               [alu_imm_pkg::XLEN-1:0]                         reg_read_data_by_bank_by_port,
  input  logic [alu_imm_pkg::PRF_BANK_COUNT-1:0]
               [alu_imm_pkg::XLEN-1:0]                         forward_data_by_bank,

  // Towards the execute stage register
  output logic                                                 ex_valid,
  output alu_imm_pkg::ex_payload_t                             ex_payload,
  input  logic                                                 ex_ready
);

  logic issue_fire;
  logic ex_fire;

  // Captured issue
  logic                                  cap_valid;
  alu_imm_pkg::alu_imm_op_t              cap_op;
  logic [alu_imm_pkg::IMM_WIDTH-1:0]     cap_imm12;
  logic                                  cap_forward;
  logic                                  cap_is_zero;
  alu_imm_pkg::bank_t                    cap_bank;
  logic                                  cap_port;
  alu_imm_pkg::pr_t                      cap_dest_pr;
  alu_imm_pkg::rob_t                     cap_rob_index;

  // Operand A from the buses and its held copy
  logic [alu_imm_pkg::XLEN-1:0]          a_bus;
  logic [alu_imm_pkg::XLEN-1:0]          a_held;
  logic                                  a_captured;

  assign issue_ready = !cap_valid || ex_ready;
  assign issue_fire  = issue_valid && issue_ready;
  assign ex_fire     = ex_valid && ex_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      cap_valid  <= 1'b0;
      a_captured <= 1'b0;
    end else if (issue_fire) begin
      cap_valid  <= 1'b1;
      a_captured <= 1'b0;
    end else if (ex_fire) begin
      cap_valid  <= 1'b0;
      a_captured <= 1'b0;
    end else if (cap_valid) begin
      // Stalled, the buses move on after this cycle
      a_captured <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (issue_fire) begin
      cap_op        <= issue_op;
      cap_imm12     <= issue_imm12;
      cap_forward   <= issue_A_forward;
      cap_is_zero   <= issue_A_is_zero;
      cap_bank      <= issue_A_bank;
      cap_port      <= A_reg_read_port;
      cap_dest_pr   <= issue_dest_PR;
      cap_rob_index <= issue_ROB_index;
    end
    if (cap_valid && !a_captured) begin
      a_held <= a_bus;
    end
  end

  // Zero wins over forward, forward wins over the register port
  always_comb begin
    if (cap_is_zero) begin
      a_bus = '0;
    end else if (cap_forward) begin
      a_bus = forward_data_by_bank[cap_bank];
    end else begin
      a_bus = reg_read_data_by_bank_by_port[cap_bank][cap_port];
    end
  end

  assign ex_valid = cap_valid;

  always_comb begin
    ex_payload.op        = cap_op;
    ex_payload.imm12     = cap_imm12;
    ex_payload.a         = a_captured ? a_held : a_bus;
    ex_payload.dest_pr   = cap_dest_pr;
    ex_payload.rob_index = cap_rob_index;
  end

  // Register sourced operands need a granted read port
  property p_read_granted;
    @(posedge CLK) disable iff (!nRST)
    (issue_fire && !issue_A_forward && !issue_A_is_zero) |-> A_reg_read_ack;
  endproperty

  a_read_granted: assert property (p_read_granted)
    else $error("register operand issued without read grant");

  // Held operand keeps the payload steady across a stall
  property p_ex_hold;
    @(posedge CLK) disable iff (!nRST)
    (ex_valid && !ex_ready) |=> (ex_valid && $stable(ex_payload));
  endproperty

  a_ex_hold: assert property (p_ex_hold)
    else $error("execute payload changed while stalled");

endmodule

// File: design/alu_imm_execute.sv
// Immediate ALU
`timescale 1ns/1ps

module alu_imm_execute (
  input  logic                     in_valid,
  input  alu_imm_pkg::ex_payload_t in_payload,
  output logic                     in_ready,

  output logic                     out_valid,
  output alu_imm_pkg::wb_payload_t out_payload,
  input  logic                     out_ready
);

  logic [alu_imm_pkg::XLEN-1:0] a;
  logic [alu_imm_pkg::XLEN-1:0] imm_sext;
  logic [4:0]                   shamt;
  logic [alu_imm_pkg::XLEN-1:0] result;

  // Handshake passes straight through
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  assign a        = in_payload.a;
  assign imm_sext = {{(alu_imm_pkg::XLEN - alu_imm_pkg::IMM_WIDTH)
                      {in_payload.imm12[alu_imm_pkg::IMM_WIDTH-1]}},
                     in_payload.imm12};
  assign shamt    = in_payload.imm12[4:0];

  always_comb begin
    case (in_payload.op)
      alu_imm_pkg::ALU_IMM_ADDI: begin
        result = a + imm_sext;
      end
      alu_imm_pkg::ALU_IMM_SLTI: begin
        result = {{(alu_imm_pkg::XLEN - 1){1'b0}}, ($signed(a) < $signed(imm_sext))};
      end
      alu_imm_pkg::ALU_IMM_SLTIU: begin
        // Sign-extended immediate compared as unsigned, as in RISC-V
        result = {{(alu_imm_pkg::XLEN - 1){1'b0}}, (a < imm_sext)};
      end
      alu_imm_pkg::ALU_IMM_XORI: begin
        result = a ^ imm_sext;
      end
      alu_imm_pkg::ALU_IMM_ORI: begin
        result = a | imm_sext;
      end
      alu_imm_pkg::ALU_IMM_ANDI: begin
        result = a & imm_sext;
      end
      alu_imm_pkg::ALU_IMM_SLLI: begin
        result = a << shamt;
      end
      alu_imm_pkg::ALU_IMM_SRLI: begin
        result = a >> shamt;
      end
      alu_imm_pkg::ALU_IMM_SRAI: begin
        result = $unsigned($signed(a) >>> shamt);
      end
      default: begin
        // Unknown codes leave A untouched
        result = a;
      end
    endcase
  end

  always_comb begin
    out_payload.data      = result;
    out_payload.dest_pr   = in_payload.dest_pr;
    out_payload.rob_index = in_payload.rob_index;
  end

endmodule

// File: design/alu_imm_pipeline.sv
// Immediate ALU pipeline top level
`timescale 1ns/1ps

module alu_imm_pipeline (
  input  logic                                                 CLK,
  input  logic                                                 nRST,

  // Issue queue
  input  logic                                                 issue_valid,
  output logic                                                 issue_ready,
  input  alu_imm_pkg::alu_imm_op_t                             issue_op,
  input  logic [alu_imm_pkg::IMM_WIDTH-1:0]                    issue_imm12,
  input  logic                                                 issue_A_forward,
  input  logic                                                 issue_A_is_zero,
  input  alu_imm_pkg::bank_t                                   issue_A_bank,
  input  alu_imm_pkg::pr_t                                     issue_dest_PR,
  input  alu_imm_pkg::rob_t                                    issue_ROB_index,

  // Read arbiter
  input  logic                                                 A_reg_read_ack,
  input  logic                                                 A_reg_read_port,

  // Register file and forwarding buses
  input  logic [alu_imm_pkg::PRF_BANK_COUNT-1:0][alu_imm_pkg::PRF_PORT_COUNT-1:0]
               [alu_imm_pkg::XLEN-1:0]                         reg_read_data_by_bank_by_port,
  input  logic [alu_imm_pkg::PRF_BANK_COUNT-1:0]
               [alu_imm_pkg::XLEN-1:0]                         forward_data_by_bank,

  // Writeback
  output logic                                                 WB_valid,
  input  logic                                                 WB_ready,
  output logic [alu_imm_pkg::XLEN-1:0]                         WB_data,
  output alu_imm_pkg::pr_t                                     WB_PR,
  output alu_imm_pkg::rob_t                                    WB_ROB_index
);

  // Operand read to execute register
  logic                     ex_valid;
  logic                     ex_ready;
  alu_imm_pkg::ex_payload_t ex_payload;

  // Execute register to ALU
  logic                     alu_in_valid;
  logic                     alu_in_ready;
  alu_imm_pkg::ex_payload_t alu_in_payload;

  // ALU to writeback register
  logic                     alu_out_valid;
  logic                     alu_out_ready;
  alu_imm_pkg::wb_payload_t alu_out_payload;

  alu_imm_pkg::wb_payload_t wb_payload;

  alu_imm_operand_read u_operand_read (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .issue_valid                   (issue_valid),
    .issue_ready                   (issue_ready),
    .issue_op                      (issue_op),
    .issue_imm12                   (issue_imm12),
    .issue_A_forward               (issue_A_forward),
    .issue_A_is_zero               (issue_A_is_zero),
    .issue_A_bank                  (issue_A_bank),
    .issue_dest_PR                 (issue_dest_PR),
    .issue_ROB_index               (issue_ROB_index),
    .A_reg_read_ack                (A_reg_read_ack),
    .A_reg_read_port               (A_reg_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .ex_valid                      (ex_valid),
    .ex_payload                    (ex_payload),
    .ex_ready                      (ex_ready)
  );

  alu_imm_stage_reg #(
    .payload_t (alu_imm_pkg::ex_payload_t)
  ) u_ex_reg (
    .CLK         (CLK),
    .nRST        (nRST),
    .in_valid    (ex_valid),
    .in_payload  (ex_payload),
    .in_ready    (ex_ready),
    .out_valid   (alu_in_valid),
    .out_payload (alu_in_payload),
    .out_ready   (alu_in_ready)
  );

  alu_imm_execute u_execute (
    .in_valid    (alu_in_valid),
    .in_payload  (alu_in_payload),
    .in_ready    (alu_in_ready),
    .out_valid   (alu_out_valid),
    .out_payload (alu_out_payload),
    .out_ready   (alu_out_ready)
  );

  alu_imm_stage_reg #(
    .payload_t (alu_imm_pkg::wb_payload_t)
  ) u_wb_reg (
    .CLK         (CLK),
    .nRST        (nRST),
    .in_valid    (alu_out_valid),
    .in_payload  (alu_out_payload),
    .in_ready    (alu_out_ready),
    .out_valid   (WB_valid),
    .out_payload (wb_payload),
    .out_ready   (WB_ready)
  );

  assign WB_data      = wb_payload.data;
  assign WB_PR        = wb_payload.dest_pr;
  assign WB_ROB_index = wb_payload.rob_index;

endmodule

// File: bench/alu_imm_pipeline_tb.sv
// Immediate ALU pipeline testbench
`timescale 1ns/1ps

module alu_imm_pipeline_tb;

  localparam int SRC_ZERO = 0;
  localparam int SRC_FWD  = 1;
  localparam int SRC_REG  = 2;

  typedef struct {
    alu_imm_pkg::alu_imm_op_t op;
    logic [11:0]              imm;
    int                       mode;
    alu_imm_pkg::bank_t       bank;
    logic                     port;
    logic [31:0]              a;
    alu_imm_pkg::pr_t         pr;
    alu_imm_pkg::rob_t        rob;
    bit                       stall;
  } stim_t;

  logic CLK;
  logic nRST;
  logic issue_valid;
  logic issue_ready;
  alu_imm_pkg::alu_imm_op_t issue_op;
  logic [11:0] issue_imm12;
  logic issue_A_forward;
  logic issue_A_is_zero;
  alu_imm_pkg::bank_t issue_A_bank;
  alu_imm_pkg::pr_t issue_dest_PR;
  alu_imm_pkg::rob_t issue_ROB_index;
  logic A_reg_read_ack;
  logic A_reg_read_port;
  logic [3:0][1:0][31:0] reg_read_data_by_bank_by_port;
  logic [3:0][31:0] forward_data_by_bank;
  logic WB_valid;
  logic WB_ready;
  logic [31:0] WB_data;
  alu_imm_pkg::pr_t WB_PR;
  alu_imm_pkg::rob_t WB_ROB_index;

  stim_t stim[$];
  alu_imm_pkg::wb_payload_t exp_q[$];
  int acc_q[$];
  alu_imm_pkg::wb_payload_t got;
  logic [31:0] rng = 32'hdc587dc4;
  int value_errors = 0;
  int other_errors = 0;
  int cycles = 0;
  int limit = 1000;
  int last_low = -1;
  int seen = 0;
  bit checking = 0;
  bit first_look = 1;

  alu_imm_pipeline u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Reference model written from the OP-IMM rules
  function automatic logic [31:0] expected_data(alu_imm_pkg::alu_imm_op_t op,
                                                logic [11:0] imm, logic [31:0] a);
    logic [31:0] imm_x;
    logic [4:0]  sh;
    imm_x = {{20{imm[11]}}, imm};
    sh = imm[4:0];
    case (op)
      alu_imm_pkg::ALU_IMM_ADDI:  return a + imm_x;
      alu_imm_pkg::ALU_IMM_SLTI:  return ($signed(a) < $signed(imm_x)) ? 32'd1 : 32'd0;
      alu_imm_pkg::ALU_IMM_SLTIU: return (a < imm_x) ? 32'd1 : 32'd0;
      alu_imm_pkg::ALU_IMM_XORI:  return a ^ imm_x;
      alu_imm_pkg::ALU_IMM_ORI:   return a | imm_x;
      alu_imm_pkg::ALU_IMM_ANDI:  return a & imm_x;
      alu_imm_pkg::ALU_IMM_SLLI:  return a << sh;
      alu_imm_pkg::ALU_IMM_SRLI:  return a >> sh;
      // Fill the vacated top bits with the sign
      alu_imm_pkg::ALU_IMM_SRAI:  return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
      default:                    return a;
    endcase
  endfunction

  task automatic add_entry(alu_imm_pkg::alu_imm_op_t op, logic [11:0] imm, int mode,
                           alu_imm_pkg::bank_t bank, logic port, logic [31:0] a,
                           alu_imm_pkg::pr_t pr, alu_imm_pkg::rob_t rob, bit stall);
    stim.push_back('{op, imm, mode, bank, port, a, pr, rob, stall});
  endtask

  task automatic check_wb(alu_imm_pkg::wb_payload_t actual, alu_imm_pkg::wb_payload_t expect_v,
                          string what);
    if (actual !== expect_v) begin
      value_errors++;
      $display("FAIL %0t: %s data %h pr %0d rob %0d, expected data %h pr %0d rob %0d",
               $time, what, actual.data, actual.dest_pr, actual.rob_index,
               expect_v.data, expect_v.dest_pr, expect_v.rob_index);
    end
  endtask

  task automatic check_bit(logic actual, logic expect_v, string what);
    if (actual !== expect_v) begin
      value_errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, actual, expect_v);
    end
  endtask

  // Bus model: noise everywhere, operand on the selected slot
  task automatic drive_buses(int pending);
    for (int b = 0; b < 4; b++) begin
      for (int p = 0; p < 2; p++) begin
        reg_read_data_by_bank_by_port[b][p] <= next_rand();
      end
      forward_data_by_bank[b] <= next_rand();
    end
    if (pending >= 0) begin
      if (stim[pending].mode == SRC_REG) begin
        reg_read_data_by_bank_by_port[stim[pending].bank][stim[pending].port] <= stim[pending].a;
      end else if (stim[pending].mode == SRC_FWD) begin
        forward_data_by_bank[stim[pending].bank] <= stim[pending].a;
      end
    end
  endtask

  task automatic drive_issue(int i);
    issue_valid     <= 1'b1;
    issue_op        <= stim[i].op;
    issue_imm12     <= stim[i].imm;
    issue_A_forward <= (stim[i].mode == SRC_FWD);
    issue_A_is_zero <= (stim[i].mode == SRC_ZERO);
    issue_A_bank    <= stim[i].bank;
    issue_dest_PR   <= stim[i].pr;
    issue_ROB_index <= stim[i].rob;
    A_reg_read_ack  <= (stim[i].mode == SRC_REG);
    A_reg_read_port <= stim[i].port;
  endtask

  task automatic fill_table();
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'h005, SRC_REG,  2'd0, 1'b0, 32'h0000_0010, 7'd1,  6'd0,  0);
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'hfff, SRC_FWD,  2'd1, 1'b0, 32'h0000_0000, 7'd2,  6'd1,  0);
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'h800, SRC_REG,  2'd2, 1'b1, 32'h1234_5678, 7'd3,  6'd2,  0);
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'h7ff, SRC_ZERO, 2'd3, 1'b0, 32'hdead_beef, 7'd4,  6'd3,  0);
    add_entry(alu_imm_pkg::ALU_IMM_SLTI,  12'hfff, SRC_REG,  2'd3, 1'b1, 32'hffff_fffe, 7'd5,  6'd4,  0);
    add_entry(alu_imm_pkg::ALU_IMM_SLTI,  12'h001, SRC_FWD,  2'd0, 1'b0, 32'h8000_0000, 7'd6,  6'd5,  0);
    add_entry(alu_imm_pkg::ALU_IMM_SLTI,  12'h800, SRC_REG,  2'd1, 1'b0, 32'h0000_0001, 7'd7,  6'd6,  0);
    add_entry(alu_imm_pkg::ALU_IMM_SLTIU, 12'hfff, SRC_REG,  2'd1, 1'b1, 32'h8000_0000, 7'd8,  6'd7,  0);
    add_entry(alu_imm_pkg::ALU_IMM_SLTIU, 12'h001, SRC_FWD,  2'd2, 1'b0, 32'hffff_ffff, 7'd9,  6'd8,  0);
    add_entry(alu_imm_pkg::ALU_IMM_SLTIU, 12'h010, SRC_ZERO, 2'd0, 1'b1, 32'h0000_0000, 7'd10, 6'd9,  0);
    add_entry(alu_imm_pkg::ALU_IMM_XORI,  12'hfff, SRC_REG,  2'd0, 1'b1, 32'h0f0f_0f0f, 7'd11, 6'd10, 0);
    add_entry(alu_imm_pkg::ALU_IMM_XORI,  12'h5a5, SRC_FWD,  2'd3, 1'b0, 32'hcafe_f00d, 7'd12, 6'd11, 0);
    add_entry(alu_imm_pkg::ALU_IMM_ORI,   12'h80f, SRC_REG,  2'd2, 1'b0, 32'h0000_1000, 7'd13, 6'd12, 0);
    add_entry(alu_imm_pkg::ALU_IMM_ORI,   12'h0f0, SRC_FWD,  2'd1, 1'b0, 32'h1111_0000, 7'd14, 6'd13, 0);
    add_entry(alu_imm_pkg::ALU_IMM_ANDI,  12'h8ff, SRC_REG,  2'd3, 1'b0, 32'habcd_ef12, 7'd15, 6'd14, 0);
    add_entry(alu_imm_pkg::ALU_IMM_ANDI,  12'h00f, SRC_REG,  2'd0, 1'b1, 32'hffff_ffff, 7'd16, 6'd15, 0);
    add_entry(alu_imm_pkg::ALU_IMM_SLLI,  12'h004, SRC_REG,  2'd1, 1'b0, 32'h8000_0001, 7'd17, 6'd16, 0);
    add_entry(alu_imm_pkg::ALU_IMM_SLLI,  12'h03f, SRC_FWD,  2'd2, 1'b0, 32'h0000_0003, 7'd18, 6'd17, 0);
    add_entry(alu_imm_pkg::ALU_IMM_SRLI,  12'h01f, SRC_REG,  2'd2, 1'b1, 32'h8000_0000, 7'd19, 6'd18, 0);
    add_entry(alu_imm_pkg::ALU_IMM_SRLI,  12'h0e8, SRC_FWD,  2'd3, 1'b0, 32'hf000_00f0, 7'd20, 6'd19, 0);
    add_entry(alu_imm_pkg::ALU_IMM_SRAI,  12'h408, SRC_REG,  2'd3, 1'b1, 32'h8765_4321, 7'd21, 6'd20, 0);
    add_entry(alu_imm_pkg::ALU_IMM_SRAI,  12'h404, SRC_REG,  2'd0, 1'b0, 32'h7654_3210, 7'd22, 6'd21, 0);
    add_entry(alu_imm_pkg::alu_imm_op_t'(4'b1000), 12'h123, SRC_REG, 2'd1, 1'b1, 32'h5555_aaaa,
              7'd23, 6'd22, 0);
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'h001, SRC_REG,  2'd1, 1'b0, 32'hffff_ffff, 7'd24, 6'd23, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SLTI,  12'h000, SRC_FWD,  2'd0, 1'b0, 32'hffff_ffff, 7'd25, 6'd24, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SLTIU, 12'h800, SRC_REG,  2'd2, 1'b1, 32'hffff_f7ff, 7'd26, 6'd25, 1);
    add_entry(alu_imm_pkg::ALU_IMM_XORI,  12'h001, SRC_ZERO, 2'd2, 1'b0, 32'h1234_0000, 7'd27, 6'd26, 1);
    add_entry(alu_imm_pkg::ALU_IMM_ORI,   12'h000, SRC_REG,  2'd3, 1'b0, 32'h0bad_cafe, 7'd28, 6'd27, 1);
    add_entry(alu_imm_pkg::ALU_IMM_ANDI,  12'hff0, SRC_FWD,  2'd3, 1'b0, 32'h1357_9bdf, 7'd29, 6'd28, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SLLI,  12'h01f, SRC_REG,  2'd0, 1'b1, 32'h0000_0001, 7'd30, 6'd29, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SRLI,  12'h001, SRC_REG,  2'd1, 1'b1, 32'hffff_ffff, 7'd31, 6'd30, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SRAI,  12'h41f, SRC_FWD,  2'd1, 1'b0, 32'h8000_0000, 7'd32, 6'd31, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SRAI,  12'h400, SRC_REG,  2'd2, 1'b0, 32'hc000_0001, 7'd33, 6'd32, 1);
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'h9ab, SRC_FWD,  2'd2, 1'b0, 32'h0000_1000, 7'd34, 6'd33, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SLTI,  12'h7ff, SRC_REG,  2'd3, 1'b1, 32'h0000_07fe, 7'd35, 6'd34, 1);
    add_entry(alu_imm_pkg::ALU_IMM_SLTIU, 12'h7ff, SRC_REG,  2'd0, 1'b0, 32'h0000_07ff, 7'd36, 6'd35, 1);
    add_entry(alu_imm_pkg::ALU_IMM_XORI,  12'h800, SRC_FWD,  2'd1, 1'b0, 32'hffff_f800, 7'd37, 6'd36, 1);
    add_entry(alu_imm_pkg::ALU_IMM_ANDI,  12'h7ff, SRC_REG,  2'd1, 1'b1, 32'hffff_ffff, 7'd38, 6'd37, 1);
    add_entry(alu_imm_pkg::ALU_IMM_ORI,   12'hfff, SRC_ZERO, 2'd3, 1'b1, 32'h7777_7777, 7'd39, 6'd38, 1);
    add_entry(alu_imm_pkg::ALU_IMM_ADDI,  12'h010, SRC_REG,  2'd2, 1'b0, 32'h7fff_fff0, 7'd127, 6'd63, 1);
  endtask

  // Cycle counter and run limit
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, writebacks still outstanding: %0d",
               cycles, exp_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  // Writeback monitor, sampled away from the driving edge
  always @(negedge CLK) begin
    if (checking) begin
      if (WB_valid) begin
        // Count every accepted writeback
        if (WB_ready) begin
          seen++;
        end
        if (exp_q.size() == 0) begin
          other_errors++;
          $display("Writeback at %0t with no instruction outstanding", $time);
        end else begin
          got.data      = WB_data;
          got.dest_pr   = WB_PR;
          got.rob_index = WB_ROB_index;
          check_wb(got, exp_q[0], "writeback");
          // No stall since acceptance means exactly three edges
          if (first_look && last_low < acc_q[0]) begin
            check_bit(cycles - acc_q[0] == 3, 1'b1, "three cycle latency");
          end
          first_look = 0;
          if (WB_ready) begin
            exp_q.pop_front();
            acc_q.pop_front();
            first_look = 1;
          end
        end
      end
      if (!WB_ready) begin
        last_low = cycles;
      end
    end
  end

  initial begin
    int idx;
    int pending;
    bit fired;
    logic [31:0] r;
    alu_imm_pkg::wb_payload_t e;
    nRST = 1'b0;
    issue_valid = 1'b0;
    issue_op = alu_imm_pkg::ALU_IMM_ADDI;
    issue_imm12 = '0;
    issue_A_forward = 1'b0;
    issue_A_is_zero = 1'b0;
    issue_A_bank = '0;
    issue_dest_PR = '0;
    issue_ROB_index = '0;
    A_reg_read_ack = 1'b0;
    A_reg_read_port = 1'b0;
    reg_read_data_by_bank_by_port = '0;
    forward_data_by_bank = '0;
    WB_ready = 1'b1;
    fill_table();
    limit = stim.size() * 10 + 200;

    repeat (8) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_bit(WB_valid, 1'b0, "WB_valid after reset");
    check_bit(issue_ready, 1'b1, "issue_ready after reset");
    checking = 1;

    idx = 0;
    pending = -1;
    @(posedge CLK);
    while (idx < stim.size() || pending >= 0) begin
      drive_buses(pending);
      if (idx < stim.size()) begin
        drive_issue(idx);
        r = next_rand();
        WB_ready <= stim[idx].stall ? (r[1:0] != 2'b00) : 1'b1;
      end else begin
        issue_valid <= 1'b0;
        WB_ready <= 1'b1;
      end
      @(negedge CLK);
      fired = issue_valid && issue_ready;
      if (fired) begin
        e.data = expected_data(stim[idx].op, stim[idx].imm,
                               (stim[idx].mode == SRC_ZERO) ? 32'd0 : stim[idx].a);
        e.dest_pr = stim[idx].pr;
        e.rob_index = stim[idx].rob;
        exp_q.push_back(e);
        acc_q.push_back(cycles);
      end
      @(posedge CLK);
      if (fired) begin
        pending = idx;
        idx++;
      end else begin
        pending = -1;
      end
    end

    while (exp_q.size() != 0) begin
      @(posedge CLK);
    end
    repeat (4) @(negedge CLK);
    check_bit(WB_valid, 1'b0, "WB_valid after drain");
    if (seen != stim.size()) begin
      other_errors++;
      $display("Writeback count %0d does not match %0d issued", seen, stim.size());
    end

    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
design/alu_imm_pkg.sv
design/alu_imm_stage_reg.sv
design/alu_imm_operand_read.sv
design/alu_imm_execute.sv
design/alu_imm_pipeline.sv
bench/alu_imm_pipeline_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the immediate ALU pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
  --top-module alu_imm_pipeline_tb -o sim_alu_imm \
  && ./obj_dir/sim_alu_imm > sim.log 2>&1 \
  || { echo "Build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
